// ==== design/gem_rx_defines.svh ====
`ifndef GEM_RX_DEFINES_SVH
`define GEM_RX_DEFINES_SVH

// ---------------------------------------------------------------------------
// Link word and frame geometry
// ---------------------------------------------------------------------------
`define GEM_WORD_W      16      // Decoder word width
`define GEM_PAYLOAD_W   56      // Three data words plus K word high byte
`define GEM_FRAME_WORDS 4       // K word and three data words

// ---------------------------------------------------------------------------
// K-characters seen in the low byte of the sync word
// ---------------------------------------------------------------------------
`define GEM_K_BC 8'hBC          // Normal rotation start
`define GEM_K_F7 8'hF7
`define GEM_K_FB 8'hFB
`define GEM_K_FD 8'hFD
`define GEM_K_FE 8'hFE          // Overflow marker
`define GEM_K_1C 8'h1C          // BC0 marker
`define GEM_K_3C 8'h3C          // Resync marker

// Latency trigger K-char
// Not in the accepted marker list so the link monitor treats it as a miss
`define GEM_K_LTNCY 8'hFC

// ---------------------------------------------------------------------------
// Counter widths and limits
// ---------------------------------------------------------------------------
`define GEM_ERR_CNT_W    8      // Link loss counter
`define GEM_ERR_CNT_MAX  8'hFE  // Stops one short of all ones

`define GEM_CODE_CNT_W   16     // Not-in-table and disparity counters
`define GEM_CODE_CNT_MAX 16'hFFFE

// Clean frames in a row before link_good goes high
`define GEM_GOOD_BX      15

`endif

// ==== design/gem_rx_pkg.sv ====
`include "gem_rx_defines.svh"

package gem_rx_pkg;

    // -----------------------------------------------------------------------
    // Raw word from the 8b/10b decoder, one flag bit per byte lane
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic [`GEM_WORD_W-1:0]   data;        // Decoded word
        logic [`GEM_WORD_W/8-1:0] isk;         // K-char per byte
        logic [`GEM_WORD_W/8-1:0] notintable;  // Symbol not in code table
        logic [`GEM_WORD_W/8-1:0] disperr;     // Running disparity error
        logic [`GEM_WORD_W/8-1:0] lossofsync;  // Decoder sync state
    } gem_rx_word_t;

    // -----------------------------------------------------------------------
    // Registered word with its classification
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic [`GEM_WORD_W-1:0] data;
        logic                   is_sync;       // K in low byte only
        logic                   is_marker;     // Good sync with accepted marker
        logic                   is_clean;      // Plain data word with no faults
        logic                   code_err;      // Any not-in-table bit
        logic                   disp_err;      // Any disparity bit
    } gem_rx_sym_t;

    // Frame phase flags
    // cew1 follows the sync word and cew0 lands on the next K word
    typedef struct packed {
        logic cew0;
        logic cew1;
        logic cew2;
        logic cew3;
    } gem_rx_phase_t;

    // -----------------------------------------------------------------------
    // Assembled frame
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic [`GEM_PAYLOAD_W-1:0]   payload;      // {w3, w2, w1, w0[15:8]}
        logic [7:0]                  k_char;       // Low byte of the K word
        logic [`GEM_FRAME_WORDS-1:0] nonzero_word; // Per word non-zero flags
        logic                        latency_trig; // K word was the FC char
    } gem_rx_frame_t;

    // -----------------------------------------------------------------------
    // Link health
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic                       link_good;       // Enough clean frames seen
        logic                       link_bad;        // Too many link losses
        logic                       link_had_err;    // Lost once or never up
        logic [`GEM_ERR_CNT_W-1:0]  errcount;        // Link loss count
        logic [`GEM_CODE_CNT_W-1:0] notintablecount;
        logic [`GEM_CODE_CNT_W-1:0] disperrcount;
    } gem_rx_status_t;

endpackage

// ==== design/gem_rx_symbol_in.sv ====
`timescale 1ns/1ps
`include "gem_rx_defines.svh"

module gem_rx_symbol_in (
    input  logic                     GEM_RX_CLK160,
    input  logic                     gem_rx_resetdone,
    input  gem_rx_pkg::gem_rx_word_t rx_word,
    output gem_rx_pkg::gem_rx_sym_t  sym
);

    // ---------------------------------------------------------------------------
    // Input register
    // ---------------------------------------------------------------------------
    gem_rx_pkg::gem_rx_word_t word_q;   // Decoder word one cycle later

    logic sync_k;      // K flag on low byte only
    logic marker_k;    // Low byte is one of the accepted markers
    logic no_fault;    // No table miss and decoder still in sync

    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            word_q <= '0;   // Flags must read as idle until the link is up
        end else begin
            word_q <= rx_word;
        end
    end

    // ---------------------------------------------------------------------------
    // Classification of the registered word
    // ---------------------------------------------------------------------------
    assign sync_k   = (word_q.isk == 2'b01);
    assign marker_k = word_q.data[7:0] inside {`GEM_K_BC, `GEM_K_F7, `GEM_K_FB,
                                               `GEM_K_FD, `GEM_K_FE, `GEM_K_1C,
                                               `GEM_K_3C};

    // Bit 1 of lossofsync is the decoder's out-of-sync state
    assign no_fault = (word_q.notintable == 2'b00) && !word_q.lossofsync[1];

    always_comb begin
        sym.data      = word_q.data;
        sym.is_sync   = sync_k;
        sym.is_marker = sync_k && marker_k && no_fault;
        sym.is_clean  = (word_q.isk == 2'b00) && no_fault; // Data word with no K bits
        sym.code_err  = |word_q.notintable;
        sym.disp_err  = |word_q.disperr;
    end

    // ---------------------------------------------------------------------------
    // Checks
    // ---------------------------------------------------------------------------

    // A marker is always a sync word, whatever flag pattern arrives
    a_marker_is_sync : assert property (
        @(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone)
        sym.is_marker |-> sym.is_sync
    ) else $error("is_marker seen without is_sync");

endmodule

// ==== design/gem_rx_frame_assembler.sv ====
`timescale 1ns/1ps
`include "gem_rx_defines.svh"

module gem_rx_frame_assembler (
    input  logic                      GEM_RX_CLK160,
    input  logic                      gem_rx_resetdone,
    input  logic                      ttc_resync,
    input  gem_rx_pkg::gem_rx_sym_t   sym,
    output gem_rx_pkg::gem_rx_phase_t phase,
    output gem_rx_pkg::gem_rx_frame_t frame
);

    // ---------------------------------------------------------------------------
    // Word holding registers
    // ---------------------------------------------------------------------------
    logic [`GEM_WORD_W-1:0] w0_reg;     // K word of the frame in flight
    logic [`GEM_WORD_W-1:0] w1_reg;     // First data word after the K word
    logic [`GEM_WORD_W-1:0] w2_reg;
    logic [`GEM_WORD_W-1:0] w3_reg;     // Last data word
    logic                   lt_reg;     // K word was the latency char
    logic                   frame_done; // Last word taken on the previous edge

    // One-of decode in the same priority order as the phase chain
    logic sel_w0;
    logic sel_w1;
    logic sel_w2;
    logic sel_w3;

    assign sel_w0 = phase.cew0;
    assign sel_w1 = !phase.cew0 && phase.cew1;
    assign sel_w2 = !phase.cew0 && !phase.cew1 && phase.cew2;
    assign sel_w3 = !phase.cew0 && !phase.cew1 && !phase.cew2 && phase.cew3;

    // ---------------------------------------------------------------------------
    // Phase shift
    // ---------------------------------------------------------------------------
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            phase <= '0;
        end else if (ttc_resync) begin
            phase <= '0;
        end else begin
            phase.cew1 <= sym.is_sync;  // Sync word now so word 1 is next
            phase.cew2 <= phase.cew1;
            phase.cew3 <= phase.cew2;
            phase.cew0 <= phase.cew3;   // Lands on the next K word
        end
    end

    // K word capture and end of frame strobe
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            w0_reg     <= '0;
            lt_reg     <= 1'b0;
            frame_done <= 1'b0;
        end else if (ttc_resync) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= sel_w3;
            if (sel_w0) begin
                w0_reg <= sym.data;
                lt_reg <= sym.is_sync && (sym.data[7:0] == `GEM_K_LTNCY);
            end
        end
    end

    // Data words
    always_ff @(posedge GEM_RX_CLK160) begin
        if (sel_w1) w1_reg <= sym.data;
        if (sel_w2) w2_reg <= sym.data;
        if (sel_w3) w3_reg <= sym.data;
    end

    // ---------------------------------------------------------------------------
    // Frame output
    // ---------------------------------------------------------------------------
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            frame.payload      <= '1;
            frame.k_char       <= '0;
            frame.nonzero_word <= '0;
            frame.latency_trig <= 1'b0;
        end else if (ttc_resync) begin
            frame.payload      <= '1;
            frame.k_char       <= '0;
            frame.nonzero_word <= '0;
            frame.latency_trig <= 1'b0;
        end else if (frame_done) begin
            frame.payload      <= {w3_reg, w2_reg, w1_reg, w0_reg[15:8]};
            frame.k_char       <= w0_reg[7:0];
            frame.nonzero_word <= {|w3_reg, |w2_reg, |w1_reg, |w0_reg[15:8]};
            frame.latency_trig <= lt_reg;
        end else begin
            frame.payload      <= '1;           // Idle pattern
            frame.nonzero_word <= '0;
            frame.latency_trig <= 1'b0;         // k_char keeps the last frame's value
        end
    end

    // ---------------------------------------------------------------------------
    // Checks
    // ---------------------------------------------------------------------------

    // More than one phase live only after a sync restarted the chain
    // The overlap can take up to three edges to shift out
    a_phase_onehot : assert property (
        @(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone || ttc_resync)
        !$onehot0(phase) |->
            ($past(sym.is_sync, 1) || $past(sym.is_sync, 2) || $past(sym.is_sync, 3))
    ) else $error("phase flags overlap with no sync restart");

endmodule

// ==== design/gem_rx_link_monitor.sv ====
`timescale 1ns/1ps
`include "gem_rx_defines.svh"

module gem_rx_link_monitor (
    input  logic                       GEM_RX_CLK160,
    input  logic                       gem_rx_resetdone,
    input  logic                       ttc_resync,
    input  gem_rx_pkg::gem_rx_sym_t    sym,
    input  gem_rx_pkg::gem_rx_phase_t  phase,
    output gem_rx_pkg::gem_rx_status_t status
);

    localparam int GOOD_W = $clog2(`GEM_GOOD_BX + 1);   // Good frame counter width

    // ---------------------------------------------------------------------------
    // Monitor state
    // ---------------------------------------------------------------------------
    logic [`GEM_FRAME_WORDS-1:0] mon_in;    // Pass bit per phase
    logic                        mon_rst;   // Last frame was not clean
    logic [GOOD_W-1:0]           mon_count; // Clean frames since last fault
    logic                        link_good;
    logic                        link_err;  // Sticky loss flag
    logic [`GEM_ERR_CNT_W-1:0]   err_count;
    logic [`GEM_CODE_CNT_W-1:0]  notintable_cnt;
    logic [`GEM_CODE_CNT_W-1:0]  disperr_cnt;

    logic any_phase;
    logic link_went_down;   // Was good and just saw a bad frame

    assign any_phase      = phase.cew0 || phase.cew1 || phase.cew2 || phase.cew3;
    assign link_went_down = link_good && mon_rst;

    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            mon_in         <= '0;
            mon_rst        <= 1'b1;     // Link never seen alive
            mon_count      <= '0;
            link_good      <= 1'b0;
            link_err       <= 1'b0;
            err_count      <= '0;
            notintable_cnt <= '0;
            disperr_cnt    <= '0;
        end else if (ttc_resync) begin
            mon_in         <= '0;
            mon_rst        <= 1'b1;
            mon_count      <= '0;
            link_good      <= 1'b0;
            link_err       <= 1'b0;
            err_count      <= '0;
            notintable_cnt <= '0;
            disperr_cnt    <= '0;
        end else begin
            // Per phase pass bits
            if (phase.cew0) begin
                mon_in[0] <= sym.is_marker;
            end else if (phase.cew1) begin
                mon_in[1] <= sym.is_clean && !phase.cew2 && !phase.cew3;
            end else if (phase.cew2) begin
                mon_in[2] <= sym.is_clean && !phase.cew3;
            end else if (phase.cew3) begin
                mon_in[3] <= sym.is_clean;
            end else begin
                mon_in <= '0;   // Gap in the stream fails the frame
            end

            mon_rst <= (mon_in != '1);

            // Clean frame run length
            if (mon_rst) begin
                mon_count <= '0;
            end else if (!link_good && phase.cew3) begin
                mon_count <= mon_count + 1'b1;
            end

            link_good <= !mon_rst && (mon_count == GOOD_W'(`GEM_GOOD_BX));

            if (link_went_down) begin
                link_err <= 1'b1;
                if (err_count != `GEM_ERR_CNT_MAX) err_count <= err_count + 1'b1;
            end

            // Code errors count only inside a frame
            if (any_phase) begin
                if (sym.code_err && notintable_cnt != `GEM_CODE_CNT_MAX)
                    notintable_cnt <= notintable_cnt + 1'b1;
                if (sym.disp_err && disperr_cnt != `GEM_CODE_CNT_MAX)
                    disperr_cnt <= disperr_cnt + 1'b1;
            end
        end
    end

    // ---------------------------------------------------------------------------
    // Status out
    // ---------------------------------------------------------------------------
    always_comb begin
        status.link_good       = link_good;
        status.link_bad        = err_count[`GEM_ERR_CNT_W-1];   // Above 127 losses
        status.link_had_err    = link_err || mon_rst;           // Lost once or never up
        status.errcount        = err_count;
        status.notintablecount = notintable_cnt;
        status.disperrcount    = disperr_cnt;
    end

    // ---------------------------------------------------------------------------
    // Checks
    // ---------------------------------------------------------------------------
    a_cnt_sat : assert property (
        @(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone)
        (err_count <= `GEM_ERR_CNT_MAX) && (notintable_cnt <= `GEM_CODE_CNT_MAX) &&
        (disperr_cnt <= `GEM_CODE_CNT_MAX)
    ) else $error("counter past its saturation value");

    // Good only after a full clean run with the previous frame clean too
    a_good_rise : assert property (
        @(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone || ttc_resync)
        $rose(link_good) |-> $past(!mon_rst) && ($past(mon_count) == `GEM_GOOD_BX)
    ) else $error("link_good rose while mon_rst was set");

endmodule

// ==== design/gem_rx_top.sv ====
`timescale 1ns/1ps

module gem_rx_top (
    input  logic                       GEM_RX_CLK160,
    input  logic                       gem_rx_resetdone,
    input  logic                       ttc_resync,       // Clears frame and link state
    input  gem_rx_pkg::gem_rx_word_t   rx_word,
    output gem_rx_pkg::gem_rx_frame_t  frame,
    output gem_rx_pkg::gem_rx_status_t status
);

    // ---------------------------------------------------------------------------
    // Internal links
    // ---------------------------------------------------------------------------
    gem_rx_pkg::gem_rx_sym_t   sym;    // Classified word to both consumers
    gem_rx_pkg::gem_rx_phase_t phase;  // Frame phase to the monitor

    // Decoder word register and classifier
    gem_rx_symbol_in u_symbol_in (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .rx_word          (rx_word),
        .sym              (sym)
    );

    // Phase chain and frame build
    gem_rx_frame_assembler u_frame_assembler (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .ttc_resync       (ttc_resync),
        .sym              (sym),
        .phase            (phase),
        .frame            (frame)
    );

    // Link health and error counters
    gem_rx_link_monitor u_link_monitor (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .ttc_resync       (ttc_resync),
        .sym              (sym),
        .phase            (phase),
        .status           (status)
    );

endmodule

// ==== dv/gem_rx_tb.sv ====
`timescale 1ns/1ps

module gem_rx_tb;

    // ---------------------------------------------------------------------------
    // Local types
    // ---------------------------------------------------------------------------
    typedef struct {
        int                         due;    // Cycle count at which to sample
        gem_rx_pkg::gem_rx_frame_t  frm;
        gem_rx_pkg::gem_rx_status_t sts;
    } check_item_t;

    // One line of the golden file
    typedef struct {
        logic [7:0]                 k;      // K-char in the low byte
        logic [7:0]                 hi;     // High byte of the K word
        logic [15:0]                w1;
        logic [15:0]                w2;
        logic [15:0]                w3;
        int                         inj;    // Injection code on the group's first frame
        int                         rep;    // Frames in the group
        gem_rx_pkg::gem_rx_frame_t  frm;    // Expected last frame
        gem_rx_pkg::gem_rx_status_t sts;    // Expected status at the last frame
    } group_t;

    // ---------------------------------------------------------------------------
    // DUT signals
    // ---------------------------------------------------------------------------
    logic                       GEM_RX_CLK160;
    logic                       gem_rx_resetdone;
    logic                       ttc_resync;
    gem_rx_pkg::gem_rx_word_t   rx_word;
    gem_rx_pkg::gem_rx_frame_t  frame;
    gem_rx_pkg::gem_rx_status_t status;

    check_item_t chk_q[$];              // Pending checks in due order
    group_t      groups[$];
    int          cycle_cnt   = 0;       // Rising edges so far
    int          cycle_limit = 100000;  // Replaced once the golden file is read

    gem_rx_top UUT (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .ttc_resync       (ttc_resync),
        .rx_word          (rx_word),
        .frame            (frame),
        .status           (status)
    );

    // 100 ns period
    initial GEM_RX_CLK160 = 1'b0;
    always #50 GEM_RX_CLK160 = ~GEM_RX_CLK160;

    // ---------------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ---------------------------------------------------------------------------
    task automatic stop_on_fail(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        string msg;
        msg = $sformatf("FAILED time %0t: %s expected %0h actual %0h", $time, name, exp, act);
        stop_on_fail(msg);
    endtask

    task automatic check_frame(input gem_rx_pkg::gem_rx_frame_t exp,
                               input gem_rx_pkg::gem_rx_frame_t act);
        if (act.payload !== exp.payload)
            report_mismatch("frame.payload", exp.payload, act.payload);
        if (act.k_char !== exp.k_char)
            report_mismatch("frame.k_char", exp.k_char, act.k_char);
        if (act.nonzero_word !== exp.nonzero_word)
            report_mismatch("frame.nonzero_word", exp.nonzero_word, act.nonzero_word);
        if (act.latency_trig !== exp.latency_trig)
            report_mismatch("frame.latency_trig", exp.latency_trig, act.latency_trig);
    endtask

    task automatic check_status(input gem_rx_pkg::gem_rx_status_t exp,
                                input gem_rx_pkg::gem_rx_status_t act);
        if (act.link_good !== exp.link_good)
            report_mismatch("status.link_good", exp.link_good, act.link_good);
        if (act.link_bad !== exp.link_bad)
            report_mismatch("status.link_bad", exp.link_bad, act.link_bad);
        if (act.link_had_err !== exp.link_had_err)
            report_mismatch("status.link_had_err", exp.link_had_err, act.link_had_err);
        if (act.errcount !== exp.errcount)
            report_mismatch("status.errcount", exp.errcount, act.errcount);
        if (act.notintablecount !== exp.notintablecount)
            report_mismatch("status.notintablecount", exp.notintablecount,
                            act.notintablecount);
        if (act.disperrcount !== exp.disperrcount)
            report_mismatch("status.disperrcount", exp.disperrcount, act.disperrcount);
    endtask

    // ---------------------------------------------------------------------------
    // Expected values that follow from the reset rules
    // ---------------------------------------------------------------------------
    function automatic gem_rx_pkg::gem_rx_frame_t idle_frame(input logic [7:0] k);
        gem_rx_pkg::gem_rx_frame_t f;
        f.payload      = '1;     // All ones between frames
        f.k_char       = k;
        f.nonzero_word = '0;
        f.latency_trig = 1'b0;
        return f;
    endfunction

    function automatic gem_rx_pkg::gem_rx_status_t reset_status();
        gem_rx_pkg::gem_rx_status_t s;
        s              = '0;
        s.link_had_err = 1'b1;   // Link never seen up
        return s;
    endfunction

    function automatic gem_rx_pkg::gem_rx_word_t make_word(input logic [15:0] data,
                                                          input logic [1:0] isk,
                                                          input logic [1:0] nit,
                                                          input logic [1:0] disp);
        gem_rx_pkg::gem_rx_word_t w;
        w.data       = data;
        w.isk        = isk;
        w.notintable = nit;
        w.disperr    = disp;
        w.lossofsync = 2'b00;
        return w;
    endfunction

    // ---------------------------------------------------------------------------
    // Stimulus
    // ---------------------------------------------------------------------------
    task automatic drive_word(input gem_rx_pkg::gem_rx_word_t w, input logic resync);
        @(negedge GEM_RX_CLK160);
        rx_word    = w;
        ttc_resync = resync;   // One cycle pulse only
    endtask

    // Injection codes: 1 not-in-table w1, 2 disparity w2, 3 dropped sync,
    // 4 non-marker K, 5 resync with w2
    task automatic send_group(input group_t g);
        logic [7:0]  k_low;
        logic [1:0]  isk;
        logic        resync;
        check_item_t item;
        for (int f = 0; f < g.rep; f++) begin
            k_low  = (f == 0 && g.inj == 4) ? 8'h5C : g.k;    // K28.2 is no marker
            isk    = (f == 0 && g.inj == 3) ? 2'b00 : 2'b01;  // Sync flag lost
            resync = (f == 0 && g.inj == 5);
            drive_word(make_word({g.hi, k_low}, isk, 2'b00, 2'b00), 1'b0);
            drive_word(make_word(g.w1, 2'b00, (f == 0 && g.inj == 1) ? 2'b01 : 2'b00,
                                 2'b00), 1'b0);
            drive_word(make_word(g.w2, 2'b00, 2'b00,
                                 (f == 0 && g.inj == 2) ? 2'b10 : 2'b00), resync);
            if (resync) begin
                item.due = cycle_cnt + 1;          // Right after the resync edge
                item.frm = idle_frame(8'h00);
                item.sts = reset_status();
                chk_q.push_back(item);
            end
            drive_word(make_word(g.w3, 2'b00, 2'b00, 2'b00), 1'b0);
            if (f == g.rep - 1) begin
                item.due = cycle_cnt + 3;          // Two edges after the last word
                item.frm = g.frm;
                item.sts = g.sts;
                chk_q.push_back(item);
            end
        end
    endtask

    task automatic read_golden();
        int          fd;
        int          n;
        string       line;
        logic [63:0] col [0:16];
        group_t      g;
        fd = $fopen("dv/gem_rx_golden.txt", "r");
        if (fd == 0) stop_on_fail("Cannot open dv/gem_rx_golden.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#") continue;  // Skip notes
            n = $sscanf(line, "%h %h %h %h %h %d %d %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                        col[15], col[16]);
            if (n != 17) stop_on_fail({"Golden file line has wrong field count: ", line});
            g.k                   = col[0][7:0];
            g.hi                  = col[1][7:0];
            g.w1                  = col[2][15:0];
            g.w2                  = col[3][15:0];
            g.w3                  = col[4][15:0];
            g.inj                 = int'(col[5]);
            g.rep                 = int'(col[6]);
            g.frm.payload         = col[7][55:0];
            g.frm.k_char          = col[8][7:0];
            g.frm.nonzero_word    = col[9][3:0];
            g.frm.latency_trig    = col[10][0];
            g.sts.link_good       = col[11][0];
            g.sts.link_bad        = col[12][0];
            g.sts.link_had_err    = col[13][0];
            g.sts.errcount        = col[14][7:0];
            g.sts.notintablecount = col[15][15:0];
            g.sts.disperrcount    = col[16][15:0];
            groups.push_back(g);
        end
        $fclose(fd);
    endtask

    // ---------------------------------------------------------------------------
    // Cycle counter, timeout and scheduled checks
    // ---------------------------------------------------------------------------
    always @(posedge GEM_RX_CLK160) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
            stop_on_fail("Timeout: the run went past its cycle limit");
    end

    always @(negedge GEM_RX_CLK160) begin : sched_checks
        check_item_t item;
        while (chk_q.size() > 0 && chk_q[0].due <= cycle_cnt) begin
            item = chk_q.pop_front();
            if (item.due != cycle_cnt) stop_on_fail("A scheduled check was missed");
            check_frame(item.frm, frame);
            check_status(item.sts, status);
        end
    end

    // ---------------------------------------------------------------------------
    // Main sequence
    // ---------------------------------------------------------------------------
    initial begin : main_seq
        int total_rep;
        gem_rx_resetdone = 1'b0;
        ttc_resync       = 1'b0;
        rx_word          = '0;
        total_rep        = 0;

        read_golden();
        if (groups.size() == 0) stop_on_fail("Golden file holds no groups");
        foreach (groups[i]) total_rep += groups[i].rep;
        cycle_limit = 4 * total_rep + 200;

        repeat (4) @(posedge GEM_RX_CLK160);     // Reset held for 4 cycles
        @(negedge GEM_RX_CLK160);
        gem_rx_resetdone = 1'b1;

        // Out of reset with an idle line
        @(negedge GEM_RX_CLK160);
        check_frame(idle_frame(8'h00), frame);
        check_status(reset_status(), status);

        foreach (groups[i]) send_group(groups[i]);

        // Idle tail lets the last checks come due
        repeat (8) drive_word('0, 1'b0);

        if (chk_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_on_fail("Some frame checks never came due");
        end
    end

endmodule

// ==== dv/gem_rx_golden.txt ====
# k hi w1 w2 w3 inj rep | payload k_char nonzero latency | good bad had_err err notintable disperr
# inj 0 none, 1 not-in-table w1, 2 disparity w2, 3 dropped sync, 4 non-marker K, 5 resync
BC 12 3456 789A BCDE 0 20 BCDE789A345612 BC F 0 1 0 0 00 0000 0000
FC 00 1111 0000 2222 0 3  22220000111100 FC A 1 0 0 1 01 0000 0000
BC A5 0001 0100 8000 0 24 800001000001A5 BC F 0 1 0 1 01 0000 0000
F7 3C 1234 5678 9ABC 3 6  9ABC567812343C F7 F 0 0 0 1 02 0000 0000
FB 00 FFFF 0F0F 00F0 1 6  00F00F0FFFFF00 FB E 0 0 0 1 02 0001 0000
FD 55 AAAA 5555 0000 2 4  00005555AAAA55 FD 7 0 0 0 1 02 0001 0001
1C 01 0202 0303 0404 0 20 04040303020201 1C F 0 1 0 1 02 0001 0001
3C 77 1357 2468 9BDF 4 5  9BDF2468135777 3C F 0 0 0 1 03 0001 0001
FE 99 CAFE F00D 0BAD 5 4  0BADF00DCAFE99 FE F 0 0 0 0 00 0000 0000

// ==== vlog.f ====
+incdir+design
design/gem_rx_pkg.sv
design/gem_rx_symbol_in.sv
design/gem_rx_frame_assembler.sv
design/gem_rx_link_monitor.sv
design/gem_rx_top.sv
dv/gem_rx_tb.sv
